// ==== all.f ====
+incdir+src
src/ice_pkg.sv
src/byte_fifo.sv
src/phase_timer.sv
src/bit_shifter.sv
src/ein_fsm.sv
src/ice_tx_top.sv
bench/ice_tx_tb.sv

// ==== bench/ice_tx_stimulus.txt ====
# cmd value [level], values in hex
# w byte | f level | s 0 | e byte | m clocks level | u level | i bytes_allowed
u 0
# one byte frame
w a5
s 0
m 4 1
e a5
i 1
m 14 0
# three bytes back to back
w 3c
w 81
w 7e
s 0
m 8 1
e 3c
e 81
e 7e
i 3
# fragment keeps the frame open
f 1
w 5a
s 0
e 5a
m 40 1
w c3
w 0f
f 0
s 0
e c3
e 0f
i 2
m 8 0
# queue full, fifth write dropped
w 11
w 22
w 33
u 0
w 44
u 1
w 99
u 1
s 0
m 4 1
e 11
e 22
e 33
e 44
i 4
u 0

// ==== bench/ice_tx_tb.sv ====
`timescale 1ns/1ps
`include "ice_defs.svh"

module ice_tx_tb;

	localparam int BYTE_TIMEOUT = 64 * `ICE_CLK_DIV; // clocks allowed per byte
	localparam string STIM_FILE = "bench/ice_tx_stimulus.txt";

	logic clk;
	logic bit_ctr_reset;
	logic wr_en;
	ice_pkg::ice_byte_t wr_data;
	logic start_tx;
	logic fragment;
	logic full;
	logic emo_out;
	logic eci_out;
	logic edi_out;

	// line decoder
	ice_pkg::ice_byte_t decoded_q [$];
	ice_pkg::ice_byte_t shift_byte = '0;
	int bit_cnt = 0;
	logic prev_eci = 1'b0;
	logic prev_edi = 1'b0;

	ice_tx_top ice_tx_top_inst (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.start_tx      (start_tx),
		.fragment      (fragment),
		.full          (full),
		.emo_out       (emo_out),
		.eci_out       (eci_out),
		.edi_out       (edi_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// failure reporting and compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_mismatch(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Done: errors found");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run aborted");
	endtask

	task automatic check_byte(input ice_pkg::ice_byte_t got, input ice_pkg::ice_byte_t want);
		if (got !== want) begin
			report_mismatch($sformatf("decoded byte %02h, expected %02h", got, want));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic want);
		if (got !== want) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, got, want));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoder, sampled away from the active edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		if (eci_out === 1'b1 && prev_eci === 1'b1 && edi_out !== prev_edi) begin
			report_mismatch("edi_out changed while eci_out was high");
		end
		if (emo_out !== 1'b1) begin
			bit_cnt = 0; // outside a frame
		end else if (eci_out === 1'b1 && prev_eci !== 1'b1) begin
			shift_byte = {edi_out, shift_byte[7:1]}; // lsb arrives first
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				decoded_q.push_back(shift_byte);
				bit_cnt = 0;
			end
		end
		prev_eci = eci_out;
		prev_edi = edi_out;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host actions, all start on a falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_write(input ice_pkg::ice_byte_t b);
		wr_data = b;
		wr_en = 1'b1;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic pulse_start();
		start_tx = 1'b1;
		@(negedge clk);
		start_tx = 1'b0;
	endtask

	task automatic check_idle_lines(input int clocks);
		repeat (clocks) begin
			@(negedge clk);
			check_level("emo_out", emo_out, 1'b0);
			check_level("eci_out", eci_out, 1'b0);
			check_level("edi_out", edi_out, 1'b0);
			check_level("full", full, 1'b0);
		end
	endtask

	task automatic expect_byte(input ice_pkg::ice_byte_t want);
		int waited;
		waited = 0;
		while (decoded_q.size() == 0) begin
			if (waited >= BYTE_TIMEOUT) begin
				abort_run($sformatf("no byte decoded within %0d clocks, was waiting for %02h",
					waited, want));
			end
			@(negedge clk);
			waited++;
		end
		check_byte(decoded_q.pop_front(), want);
	endtask

	task automatic expect_emo_after(input int clocks, input logic level);
		repeat (clocks) @(negedge clk);
		check_level("emo_out", emo_out, level);
	endtask

	task automatic wait_frame_end(input int bytes);
		int waited;
		int limit;
		waited = 0;
		limit = BYTE_TIMEOUT * ((bytes > 0) ? bytes : 1);
		while (emo_out !== 1'b0) begin
			if (waited >= limit) begin
				abort_run($sformatf("emo_out did not fall within %0d clocks", limit));
			end
			@(negedge clk);
			waited++;
		end
		if (decoded_q.size() != 0) begin
			report_mismatch($sformatf("%0d extra bytes decoded in the frame", decoded_q.size()));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int fd;
		int fields;
		string line;
		byte cmd;
		logic [31:0] val_a;
		logic [31:0] val_b;

		bit_ctr_reset = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		start_tx = 1'b0;
		fragment = 1'b0;
		repeat (2) @(negedge clk);
		bit_ctr_reset = 1'b0;

		check_idle_lines(20); // quiet after reset

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			abort_run("could not open the stimulus file bench/ice_tx_stimulus.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			val_a = '0;
			val_b = '0;
			fields = $sscanf(line, "%c %h %h", cmd, val_a, val_b);
			if (cmd == "m" && fields < 3) begin
				abort_run($sformatf("stimulus line needs a clock count and a level: %s", line));
			end
			case (cmd)
				"w": drive_write(val_a[7:0]);
				"f": fragment = val_a[0];
				"s": pulse_start();
				"e": expect_byte(val_a[7:0]);
				"m": expect_emo_after(int'(val_a), val_b[0]);
				"u": check_level("full", full, val_a[0]);
				"i": wait_frame_end(int'(val_a));
				default: abort_run($sformatf("unknown stimulus command in line: %s", line));
			endcase
		end
		$fclose(fd);

		if (decoded_q.size() != 0) begin
			$display("ERROR at %0t ns: %0d decoded bytes left unchecked", $time, decoded_q.size());
			$display("Done: errors found");
			$fatal(1, "unchecked bytes at end of run");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// ==== src/bit_shifter.sv ====
`timescale 1ns/1ps

module bit_shifter (
	input  logic               clk,
	input  logic               bit_ctr_reset,
	input  logic               bit_clear,
	input  logic               bit_advance,
	input  ice_pkg::ice_byte_t head_byte,
	output logic               data_bit,
	output logic               pop
);

	localparam ice_pkg::bit_idx_t LAST_BIT = 3'd7;

	ice_pkg::bit_idx_t bit_idx;
	logic last_bit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bit index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			bit_idx <= '0;
		end else if (bit_clear) begin
			bit_idx <= '0; // start phase of a frame
		end else if (bit_advance) begin
			bit_idx <= bit_idx + 3'd1; // 7 wraps to 0
		end
	end

	assign last_bit = (bit_idx == LAST_BIT);

	// lsb first
	assign data_bit = head_byte[bit_idx];

	// done with this byte, let the next one fall through
	assign pop = bit_advance && last_bit;

endmodule

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`include "ice_defs.svh"

module byte_fifo (
	input  logic               clk,
	input  logic               bit_ctr_reset,
	input  logic               wr_en,
	input  ice_pkg::ice_byte_t wr_data,
	input  logic               pop,
	output ice_pkg::ice_byte_t head_byte,
	output logic               empty,
	output logic               full
);

	localparam int unsigned AW = `ICE_FIFO_AW;
	localparam int unsigned CW = `ICE_FIFO_AW + 1;
	localparam logic [AW-1:0] LAST_IDX = AW'(`ICE_FIFO_DEPTH - 1);
	localparam logic [CW-1:0] DEPTH_C = CW'(`ICE_FIFO_DEPTH);

	ice_pkg::ice_byte_t mem [`ICE_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign push_ok = wr_en && !full; // dropped when full
	assign pop_ok = pop && !empty;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	assign head_byte = mem[rd_ptr]; // fall-through head

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign empty = (count == '0);
	assign full = (count == DEPTH_C);

	// shifter only pops the byte it has just finished sending
	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (bit_ctr_reset)
		pop |-> !empty
	) else $error("byte_fifo: pop while empty");

endmodule

// ==== src/ein_fsm.sv ====
`timescale 1ns/1ps

module ein_fsm (
	input  logic clk,
	input  logic bit_ctr_reset,
	input  logic start_tx,
	input  logic fragment,
	input  logic empty,
	input  logic phase_last,
	input  logic bit_tick,
	input  logic data_bit,
	output logic phase_restart,
	output logic bit_clear,
	output logic bit_advance,
	output logic emo_out,
	output logic eci_out,
	output logic edi_out
);

	ice_pkg::ein_state_t state;
	ice_pkg::ein_state_t next_state;
	logic next_emo;
	logic next_eci;
	logic next_edi;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state and line registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			state <= ice_pkg::EIN_IDLE;
			emo_out <= 1'b0;
			eci_out <= 1'b0;
			edi_out <= 1'b0;
		end else begin
			state <= next_state;
			emo_out <= next_emo;
			eci_out <= next_eci;
			edi_out <= next_edi;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		next_emo = 1'b1;
		next_eci = 1'b0;
		next_edi = edi_out; // held unless a data phase
		case (state)
			ice_pkg::EIN_IDLE: begin
				next_emo = 1'b0;
				if (start_tx) begin
					next_state = ice_pkg::EIN_START;
				end
			end
			ice_pkg::EIN_START: begin
				if (phase_last) begin
					next_state = ice_pkg::EIN_LOW_HOLD;
				end
			end
			ice_pkg::EIN_LOW_HOLD: begin
				if (phase_last) begin
					next_state = ice_pkg::EIN_LOW_DATA;
				end
			end
			ice_pkg::EIN_LOW_DATA: begin
				next_edi = data_bit;
				if (phase_last) begin
					next_state = ice_pkg::EIN_HIGH_DATA;
				end
			end
			ice_pkg::EIN_HIGH_DATA: begin
				next_eci = 1'b1;
				next_edi = data_bit;
				if (phase_last) begin
					next_state = ice_pkg::EIN_HIGH_HOLD;
				end
			end
			ice_pkg::EIN_HIGH_HOLD: begin
				next_eci = 1'b1;
				if (phase_last) begin
					// pop already landed, empty reflects the rest
					if (!empty) begin
						next_state = ice_pkg::EIN_LOW_HOLD;
					end else if (fragment) begin
						next_state = ice_pkg::EIN_FRAG_WAIT;
					end else begin
						next_state = ice_pkg::EIN_IDLE;
					end
				end
			end
			ice_pkg::EIN_FRAG_WAIT: begin
				if (start_tx) begin
					next_state = ice_pkg::EIN_START; // same frame goes on
				end
			end
			default: begin
				next_state = ice_pkg::EIN_IDLE;
			end
		endcase
	end

	assign phase_restart = (next_state != state);
	assign bit_clear = (state == ice_pkg::EIN_START);
	assign bit_advance = (state == ice_pkg::EIN_HIGH_HOLD) && bit_tick;

	a_eci_inside_frame: assert property (
		@(posedge clk) disable iff (bit_ctr_reset)
		eci_out |-> emo_out
	) else $error("ein_fsm: eci high outside a frame");

endmodule

// ==== src/ice_defs.svh ====
`ifndef ICE_DEFS_SVH
`define ICE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bit timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// system clocks per phase, four phases per bit
`define ICE_CLK_DIV 8
// phase counter width
`define ICE_CLK_DIV_LOG2 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ICE_FIFO_DEPTH 4
`define ICE_FIFO_AW 2

`endif

// ==== src/ice_pkg.sv ====
package ice_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// payload types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0] ice_byte_t;

	// index of a bit within one byte
	typedef logic [2:0] bit_idx_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		EIN_IDLE,      // emo low, waiting for start_tx
		EIN_START,     // one phase of emo high before bit 0
		EIN_LOW_HOLD,  // eci low, previous bit held
		EIN_LOW_DATA,  // eci low, new bit out
		EIN_HIGH_DATA, // eci high
		EIN_HIGH_HOLD, // eci high, bit counter steps here
		EIN_FRAG_WAIT  // frame kept open
	} ein_state_t;

endpackage

// ==== src/ice_tx_top.sv ====
`timescale 1ns/1ps

module ice_tx_top (
	input  logic               clk,
	input  logic               bit_ctr_reset,
	input  logic               wr_en,
	input  ice_pkg::ice_byte_t wr_data,
	input  logic               start_tx,
	input  logic               fragment,
	output logic               full,
	output logic               emo_out,
	output logic               eci_out,
	output logic               edi_out
);

	ice_pkg::ice_byte_t head_byte;
	logic empty;
	logic pop;
	logic phase_restart;
	logic phase_last;
	logic bit_tick;
	logic bit_clear;
	logic bit_advance;
	logic data_bit;

	byte_fifo byte_fifo_inst (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.pop           (pop),
		.head_byte     (head_byte),
		.empty         (empty),
		.full          (full)
	);

	phase_timer phase_timer_inst (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.phase_restart (phase_restart),
		.phase_last    (phase_last),
		.bit_tick      (bit_tick)
	);

	bit_shifter bit_shifter_inst (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.bit_clear     (bit_clear),
		.bit_advance   (bit_advance),
		.head_byte     (head_byte),
		.data_bit      (data_bit),
		.pop           (pop)
	);

	ein_fsm ein_fsm_inst (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.start_tx      (start_tx),
		.fragment      (fragment),
		.empty         (empty),
		.phase_last    (phase_last),
		.bit_tick      (bit_tick),
		.data_bit      (data_bit),
		.phase_restart (phase_restart),
		.bit_clear     (bit_clear),
		.bit_advance   (bit_advance),
		.emo_out       (emo_out),
		.eci_out       (eci_out),
		.edi_out       (edi_out)
	);

endmodule

// ==== src/phase_timer.sv ====
`timescale 1ns/1ps
`include "ice_defs.svh"

module phase_timer (
	input  logic clk,
	input  logic bit_ctr_reset,
	input  logic phase_restart,
	output logic phase_last,
	output logic bit_tick
);

	localparam int unsigned CNT_W = `ICE_CLK_DIV_LOG2;
	localparam logic [CNT_W-1:0] LAST_C = CNT_W'(`ICE_CLK_DIV - 1);
	localparam logic [CNT_W-1:0] TICK_C = CNT_W'(`ICE_CLK_DIV - 3);

	logic [CNT_W-1:0] phase_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			phase_cnt <= '0;
		end else if (phase_restart) begin
			phase_cnt <= '0; // state change starts a new phase
		end else if (phase_last) begin
			phase_cnt <= '0; // free-runs in idle and fragment wait
		end else begin
			phase_cnt <= phase_cnt + 1'b1;
		end
	end

	assign phase_last = (phase_cnt == LAST_C);
	// two clocks early so the queue pop settles before the phase end
	assign bit_tick = (phase_cnt == TICK_C);

	a_cnt_in_range: assert property (
		@(posedge clk) disable iff (bit_ctr_reset)
		phase_cnt <= LAST_C
	) else $error("phase_timer: count past last phase clock");

endmodule
